// ==== common/mmuPkg.sv ====
package mmuPkg;

    // ####################################################################
    // Data widths
    // ####################################################################

    typedef logic [31:0] wordT;   // Address or register data
    typedef logic [18:0] vpn2T;   // Virtual page-pair number, VA[31:13]
    typedef logic [19:0] pfnT;    // Physical frame number, EntryLo[25:6]

    // ####################################################################
    // Command, register and result encodings
    // ####################################################################

    typedef enum logic [2:0] {
        cmdNone,
        cmdReadReg,
        cmdWriteReg,
        cmdProbeTlb,
        cmdReadTlb,
        cmdWriteTlb,
        cmdWriteTlbRandom
    } mmuCmdE;

    typedef enum logic [2:0] {
        regIndex,
        regRandom,
        regEntryLo0,
        regEntryLo1,
        regEntryHi,
        regWired
    } mmuRegE;

    typedef enum logic [2:0] {
        excNone,
        excTlbMiss,
        excTlbLoad,
        excTlbStore,
        excTlbModified
    } mmuExcE;

    typedef enum logic {
        accessLoad,
        accessStore
    } accessE;

    typedef enum logic [1:0] {
        stateIdle,
        stateLookup,
        stateCommit
    } fsmStateE;

    // Register field positions
    localparam int   loValidBit        = 1;
    localparam int   loDirtyBit        = 2;
    localparam int   pfnLsb            = 6;
    localparam int   pfnMsb            = 25;
    localparam wordT entryHiMask       = 32'hFFFF_E000;  // Keeps VPN2 only
    localparam int   indexProbeFailBit = 31;

endpackage

// ==== common/tlbIf.sv ====
`timescale 1ns/1ps

interface tlbIf import mmuPkg::*; #(
    parameter int indexWidth = 4
);
    // Register contents
    wordT                  entryHi;
    wordT                  entryLo0;
    wordT                  entryLo1;
    wordT                  index;
    logic [indexWidth-1:0] randomIndex;

    // Command strobes
    logic                  we;
    logic                  useRandom;
    logic                  readBack;

    // Captured entry contents and probe result
    wordT                  rdEntryHi;
    wordT                  rdEntryLo0;
    wordT                  rdEntryLo1;
    logic                  probeHit;
    logic [indexWidth-1:0] probeIndex;

    modport regs (
        output entryHi, entryLo0, entryLo1, index,
        input  rdEntryHi, rdEntryLo0, rdEntryLo1, probeHit, probeIndex
    );

    modport tlb (
        input  entryHi, entryLo0, entryLo1, index, randomIndex, we, useRandom, readBack,
        output rdEntryHi, rdEntryLo0, rdEntryLo1, probeHit, probeIndex
    );

    modport ctrl (
        output we, useRandom, readBack
    );

endinterface

// ==== design/mmuTop.sv ====
`timescale 1ns/1ps

module mmuTop import mmuPkg::*; #(
    parameter int indexWidth = 4
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   addrValid,
    input  wordT   vAddr,
    input  accessE accessType,
    output logic   resultValid,
    output wordT   pAddr,
    output mmuExcE exception,
    input  logic   cmdValid,
    input  mmuCmdE cmd,
    input  mmuRegE regSel,
    input  wordT   dataIn,
    output wordT   dataOut,
    output logic   dataValid,
    output logic   busy,
    output logic   cmdDone
);

    logic                  regWe;
    logic                  regRe;
    logic                  loadProbe;
    logic                  loadTlbRead;
    logic [indexWidth-1:0] randomIndex;
    logic [indexWidth-1:0] wired;
    logic                  wiredWrite;
    logic                  hit;
    wordT                  hitLo;

    tlbIf #(.indexWidth(indexWidth)) tlbBus ();

    assign tlbBus.randomIndex = randomIndex;

    // ####################################################################
    // Command path
    // ####################################################################

    mmuCmdFsm u_cmdFsm (
        .clk(clk), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd), .ctrl(tlbBus),
        .regWe(regWe), .regRe(regRe), .loadProbe(loadProbe), .loadTlbRead(loadTlbRead),
        .busy(busy), .cmdDone(cmdDone)
    );

    randomCounter #(.indexWidth(indexWidth)) u_randomCounter (
        .clk(clk), .rstN(rstN), .wired(wired), .wiredWrite(wiredWrite),
        .randomIndex(randomIndex)
    );

    mmuRegFile #(.indexWidth(indexWidth)) u_regFile (
        .clk(clk), .rstN(rstN), .regWe(regWe), .regRe(regRe), .loadProbe(loadProbe),
        .loadTlbRead(loadTlbRead), .regSel(regSel), .dataIn(dataIn),
        .randomIndex(randomIndex), .regs(tlbBus), .wired(wired), .wiredWrite(wiredWrite),
        .dataOut(dataOut), .dataValid(dataValid)
    );

    // ####################################################################
    // Translation path
    // ####################################################################

    tlbArray #(.indexWidth(indexWidth)) u_tlbArray (
        .clk(clk), .rstN(rstN), .tlb(tlbBus), .vAddr(vAddr),
        .hit(hit), .hitLo(hitLo), .hitIndex()
    );

    addrTranslator u_addrTranslator (
        .clk(clk), .rstN(rstN), .addrValid(addrValid), .vAddr(vAddr),
        .accessType(accessType), .hit(hit), .hitLo(hitLo),
        .resultValid(resultValid), .pAddr(pAddr), .exception(exception)
    );

endmodule

// ==== dv/mmuTb.sv ====
`timescale 1ns/1ps

module mmuTb import mmuPkg::*; ();

    localparam int                    indexWidth = 4;
    localparam int                    entryCount = 1 << indexWidth;
    localparam logic [indexWidth-1:0] topEntry   = '1;
    localparam wordT                  probeFail  = 32'h8000_0000;

    logic   clk;
    logic   rstN;
    logic   addrValid;
    wordT   vAddr;
    accessE accessType;
    logic   resultValid;
    wordT   pAddr;
    mmuExcE exception;
    logic   cmdValid;
    mmuCmdE cmd;
    mmuRegE regSel;
    wordT   dataIn;
    wordT   dataOut;
    logic   dataValid;
    logic   busy;
    logic   cmdDone;

    // Reference model of the TLB entries and the registers
    vpn2T                  modelVpn2  [entryCount];
    wordT                  modelLo0   [entryCount];
    wordT                  modelLo1   [entryCount];
    logic                  modelValid [entryCount];
    wordT                  modelIndex;
    wordT                  modelLo0Reg;
    wordT                  modelLo1Reg;
    wordT                  modelEntryHi;
    logic [indexWidth-1:0] modelWired;
    logic [indexWidth-1:0] modelRandom;
    logic [indexWidth-1:0] snapRandom;
    logic [indexWidth-1:0] commitRandom;
    logic [4:0]            excSeen;
    integer                seed = 68611;
    int                    opCount;
    int                    cycleCount;

    mmuTop #(.indexWidth(indexWidth)) u_dut (
        .clk(clk), .rstN(rstN), .addrValid(addrValid), .vAddr(vAddr),
        .accessType(accessType), .resultValid(resultValid), .pAddr(pAddr),
        .exception(exception), .cmdValid(cmdValid), .cmd(cmd), .regSel(regSel),
        .dataIn(dataIn), .dataOut(dataOut), .dataValid(dataValid), .busy(busy),
        .cmdDone(cmdDone)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random counts down to Wired and wraps to the top entry
    always @(posedge clk or negedge rstN) begin
        if (!rstN)
            modelRandom <= topEntry;
        else if (cmdValid && cmd == cmdWriteReg && regSel == regWired)
            modelRandom <= topEntry;
        else if (modelRandom == modelWired)
            modelRandom <= topEntry;
        else
            modelRandom <= modelRandom - 1'b1;
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > 10 * (opCount + 2))
                failNow("Watchdog timeout: the run outlasted ten cycles per issued operation");
        end
    end

    // ####################################################################
    // Reference functions and compare tasks
    // ####################################################################

    function automatic void refTranslate(input wordT va, input accessE acc,
                                         output wordT expAddr, output mmuExcE expExc);
        logic hit;
        wordT lo;
        hit = 1'b0;
        lo  = '0;
        for (int i = 0; i < entryCount; i++) begin
            if (modelValid[i] && modelVpn2[i] == va[31:13]) begin
                hit = 1'b1;
                lo  = va[12] ? modelLo1[i] : modelLo0[i];   // Odd page when bit 12 is set
            end
        end
        if (!hit)
            expExc = excTlbMiss;
        else if (!lo[loValidBit])
            expExc = (acc == accessStore) ? excTlbStore : excTlbLoad;
        else if (acc == accessStore && !lo[loDirtyBit])
            expExc = excTlbModified;
        else
            expExc = excNone;
        expAddr = (expExc == excNone) ? {lo[25:6], va[11:0]} : '0;
    endfunction

    function automatic void refProbe(input vpn2T key, output logic hit,
                                     output logic [indexWidth-1:0] idx);
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < entryCount; i++) begin
            if (modelValid[i] && modelVpn2[i] == key) begin
                hit = 1'b1;
                idx = i[indexWidth-1:0];
            end
        end
    endfunction

    function automatic vpn2T freshVpn2();
        vpn2T                  vpn;
        logic                  hit;
        logic [indexWidth-1:0] idx;
        hit = 1'b1;
        while (hit) begin
            vpn = vpn2T'($random(seed));
            refProbe(vpn, hit, idx);
        end
        return vpn;
    endfunction

    function automatic wordT modelReg(input mmuRegE sel);
        case (sel)
            regIndex:    return modelIndex;
            regRandom:   return wordT'(snapRandom);
            regEntryLo0: return modelLo0Reg;
            regEntryLo1: return modelLo1Reg;
            regEntryHi:  return modelEntryHi;
            default:     return wordT'(modelWired);
        endcase
    endfunction

    task automatic failNow(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected)
            failNow($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkExc(input string name, input mmuExcE expected, input mmuExcE actual);
        if (actual !== expected)
            failNow($sformatf("FAIL %s expected %s actual %s", name, expected.name(),
                              actual.name()));
    endtask

    task automatic checkIndex(input string name, input logic [indexWidth-1:0] expected,
                              input logic [indexWidth-1:0] actual);
        if (actual !== expected)
            failNow($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
    endtask

    // ####################################################################
    // Bus operations
    // ####################################################################

    task automatic awaitStrobe(input string what);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            case (what)
                "result": seen = resultValid;
                "data":   seen = dataValid;
                default:  seen = cmdDone;
            endcase
            waited++;
            if (!seen && waited > 4)
                failNow({"The DUT gave no ", what, " strobe in time"});
        end
    endtask

    task automatic issueCmd(input mmuCmdE c, input mmuRegE sel, input wordT data);
        @(posedge clk);
        cmdValid <= 1'b1;
        cmd      <= c;
        regSel   <= sel;
        dataIn   <= data;
        @(negedge clk);
        snapRandom = modelRandom;   // Random as the read port sees it
        @(posedge clk);
        cmdValid <= 1'b0;
        cmd      <= cmdNone;
        opCount++;
    endtask

    task automatic writeReg(input mmuRegE sel, input wordT data);
        issueCmd(cmdWriteReg, sel, data);
        case (sel)
            regIndex:    modelIndex   = data & (probeFail | wordT'(entryCount - 1));
            regEntryLo0: modelLo0Reg  = data;
            regEntryLo1: modelLo1Reg  = data;
            regEntryHi:  modelEntryHi = data & 32'hFFFF_E000;
            regWired:    modelWired   = data[indexWidth-1:0];
            default:     ;
        endcase
    endtask

    task automatic readReg(input mmuRegE sel, output wordT value);
        issueCmd(cmdReadReg, sel, '0);
        awaitStrobe("data");
        value = dataOut;
    endtask

    task automatic checkReg(input mmuRegE sel, input string name);
        wordT got;
        readReg(sel, got);
        checkWord(name, modelReg(sel), got);
    endtask

    task automatic finishTlbCmd(input mmuCmdE c);
        logic                  hit;
        logic [indexWidth-1:0] idx;
        logic [indexWidth-1:0] slot;
        awaitStrobe("done");
        commitRandom = modelRandom;
        slot = (c == cmdWriteTlbRandom) ? modelRandom : modelIndex[indexWidth-1:0];
        case (c)
            cmdProbeTlb: begin
                refProbe(modelEntryHi[31:13], hit, idx);
                modelIndex = hit ? wordT'(idx) : probeFail;
            end
            cmdReadTlb: begin
                modelEntryHi = modelValid[slot] ? {modelVpn2[slot], 13'b0} : '0;
                modelLo0Reg  = modelValid[slot] ? modelLo0[slot] : '0;
                modelLo1Reg  = modelValid[slot] ? modelLo1[slot] : '0;
            end
            default: begin
                modelVpn2[slot]  = modelEntryHi[31:13];
                modelLo0[slot]   = modelLo0Reg;
                modelLo1[slot]   = modelLo1Reg;
                modelValid[slot] = 1'b1;
            end
        endcase
    endtask

    task automatic tlbCmd(input mmuCmdE c);
        issueCmd(c, regIndex, '0);
        finishTlbCmd(c);
    endtask

    task automatic loadEntryRegs(input wordT lo0, input wordT lo1);
        // Junk in the low EntryHi bits must be masked off
        writeReg(regEntryHi, {freshVpn2(), 13'b0} | (wordT'($random(seed)) & 32'h1FFF));
        writeReg(regEntryLo0, lo0);
        writeReg(regEntryLo1, lo1);
    endtask

    task automatic translate(input wordT va, input accessE acc, input string name);
        wordT   expAddr;
        mmuExcE expExc;
        refTranslate(va, acc, expAddr, expExc);
        @(posedge clk);
        addrValid  <= 1'b1;
        vAddr      <= va;
        accessType <= acc;
        @(posedge clk);
        addrValid <= 1'b0;
        opCount++;
        awaitStrobe("result");
        checkExc(name, expExc, exception);
        checkWord(name, expAddr, pAddr);
        excSeen[int'(expExc)] = 1'b1;
    endtask

    // ####################################################################
    // Test sequence
    // ####################################################################

    initial begin
        wordT lo0;
        wordT lo1;
        wordT got;
        logic [indexWidth-1:0] slot;
        mmuRegE sel;
        rstN       = 1'b0;
        addrValid  = 1'b0;
        vAddr      = '0;
        accessType = accessLoad;
        cmdValid   = 1'b0;
        cmd        = cmdNone;
        regSel     = regIndex;
        dataIn     = '0;
        opCount    = 0;
        excSeen    = '0;
        modelIndex   = '0;
        modelLo0Reg  = '0;
        modelLo1Reg  = '0;
        modelEntryHi = '0;
        modelWired   = '0;
        for (int i = 0; i < entryCount; i++)
            modelValid[i] = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        for (int s = 0; s < 6; s++) begin
            sel = mmuRegE'(s);
            checkReg(sel, $sformatf("reset value of %s", sel.name()));
        end
        translate($random(seed), accessLoad, "miss after reset");
        translate($random(seed), accessStore, "miss after reset");

        for (int round = 0; round < 4; round++) begin
            for (int s = 0; s < 6; s++) begin
                sel = mmuRegE'(s);
                writeReg(sel, $random(seed));
                checkReg(sel, $sformatf("masked write of %s", sel.name()));
            end
        end
        writeReg(regWired, '0);

        // V and D come from the entry number so every exception kind shows up
        for (int i = 0; i < entryCount; i++) begin
            lo0 = $random(seed);
            lo1 = $random(seed);
            lo0[2:1] = i[1:0];
            lo1[2:1] = i[3:2];
            writeReg(regIndex, i);
            loadEntryRegs(lo0, lo1);
            tlbCmd(cmdWriteTlb);
        end
        for (int i = 0; i < 4 * entryCount; i++)
            translate({modelVpn2[i % entryCount], i[4], 12'($random(seed))},
                      accessE'(i[5]), $sformatf("translate entry %0d", i % entryCount));
        for (int i = 0; i < 16; i++)
            translate($random(seed), accessE'(i[0]), "translate absent page");
        if (excSeen != 5'b11111)
            failNow("The translation sweep did not produce every exception kind");

        for (int i = 0; i < entryCount; i++) begin
            writeReg(regEntryHi, {modelVpn2[i], 13'h0A5});
            tlbCmd(cmdProbeTlb);
            checkReg(regIndex, "probe of a written page pair");
        end
        for (int i = 0; i < 4; i++) begin
            writeReg(regEntryHi, {freshVpn2(), 13'b0});
            tlbCmd(cmdProbeTlb);
            checkReg(regIndex, "probe of an absent page pair");
        end

        for (int i = entryCount - 1; i >= 0; i--) begin
            writeReg(regIndex, i);
            tlbCmd(cmdReadTlb);
            checkReg(regEntryHi, "readTlb EntryHi");
            checkReg(regEntryLo0, "readTlb EntryLo0");
            checkReg(regEntryLo1, "readTlb EntryLo1");
        end

        writeReg(regWired, 4);
        for (int k = 0; k < 12; k++) begin
            loadEntryRegs($random(seed), $random(seed));
            tlbCmd(cmdWriteTlbRandom);
            slot = commitRandom;
            tlbCmd(cmdProbeTlb);
            readReg(regIndex, got);
            if (!got[31] && got[indexWidth-1:0] < 4)
                failNow("A random TLB write landed in a wired entry");
            checkIndex("random write slot", slot, got[indexWidth-1:0]);
            checkWord("probe after random write", modelIndex, got);
        end

        // A register write that arrives while busy must be dropped
        loadEntryRegs($random(seed), $random(seed));
        @(posedge clk);
        cmdValid <= 1'b1;
        cmd      <= cmdWriteTlbRandom;
        @(posedge clk);
        cmd    <= cmdWriteReg;
        regSel <= regEntryHi;
        dataIn <= ~modelEntryHi;
        @(negedge clk);
        if (busy !== 1'b1)
            failNow("busy was low while a TLB command was running");
        @(posedge clk);
        cmdValid <= 1'b0;
        cmd      <= cmdNone;
        opCount += 2;
        finishTlbCmd(cmdWriteTlbRandom);
        checkReg(regEntryHi, "EntryHi after a write sent while busy");
        tlbCmd(cmdProbeTlb);
        checkReg(regIndex, "probe after the busy write");

        for (int i = 0; i < 4; i++)
            translate({modelVpn2[i], i[0], 12'($random(seed))}, accessE'(i[1]),
                      $sformatf("wired entry %0d", i));

        if (u_dut.u_checker.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            failNow("The bound assertion checker reported errors");
        end
    end

endmodule

// ==== dv/mmuTb_checker.sv ====
`timescale 1ns/1ps

module mmuTbChecker import mmuPkg::*; #(
    parameter int indexWidth = 4
) (
    input logic                  clk,
    input logic                  rstN,
    input logic                  addrValid,
    input logic                  resultValid,
    input logic                  cmdValid,
    input mmuCmdE                cmd,
    input logic                  busy,
    input logic                  cmdDone,
    input logic [indexWidth-1:0] randomIndex,
    input logic [indexWidth-1:0] wired
);

    int   failCount = 0;
    logic tlbAccept;

    assign tlbAccept = cmdValid && !busy &&
                       (cmd inside {cmdProbeTlb, cmdReadTlb, cmdWriteTlb, cmdWriteTlbRandom});

    resultFollows: assert property (@(posedge clk) disable iff (!rstN)
        addrValid |=> resultValid)
    else begin
        failCount++;
        $error("resultValid did not follow addrValid by one cycle");
    end

    resultNeedsRequest: assert property (@(posedge clk) disable iff (!rstN)
        !addrValid |=> !resultValid)
    else begin
        failCount++;
        $error("resultValid pulsed without a request");
    end

    // A TLB command holds busy and finishes in its commit cycle
    doneAfterTwo: assert property (@(posedge clk) disable iff (!rstN)
        tlbAccept |=> busy ##1 (busy && cmdDone))
    else begin
        failCount++;
        $error("cmdDone did not come two cycles after the TLB command");
    end

    randomInRange: assert property (@(posedge clk) disable iff (!rstN)
        randomIndex >= wired)
    else begin
        failCount++;
        $error("Random fell below Wired");
    end

endmodule

bind mmuTop mmuTbChecker #(.indexWidth(indexWidth)) u_checker (
    .clk(clk), .rstN(rstN), .addrValid(addrValid), .resultValid(resultValid),
    .cmdValid(cmdValid), .cmd(cmd), .busy(busy), .cmdDone(cmdDone),
    .randomIndex(randomIndex), .wired(wired)
);

// ==== mmu/addrTranslator.sv ====
`timescale 1ns/1ps

module addrTranslator import mmuPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   addrValid,
    input  wordT   vAddr,
    input  accessE accessType,
    input  logic   hit,
    input  wordT   hitLo,
    output logic   resultValid,
    output wordT   pAddr,
    output mmuExcE exception
);

    mmuExcE excNext;
    pfnT    pfn;

    assign pfn = hitLo[pfnMsb:pfnLsb];

    // Miss first, then invalid page, then clean page on a store
    always_comb begin
        if (!hit) begin
            excNext = excTlbMiss;
        end else if (!hitLo[loValidBit]) begin
            excNext = (accessType == accessStore) ? excTlbStore : excTlbLoad;
        end else if (accessType == accessStore && !hitLo[loDirtyBit]) begin
            excNext = excTlbModified;
        end else begin
            excNext = excNone;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= addrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (addrValid) begin
            exception <= excNext;
            pAddr     <= (excNext == excNone) ? {pfn, vAddr[11:0]} : '0;
        end
    end

endmodule

// ==== mmu/mmuCmdFsm.sv ====
`timescale 1ns/1ps

module mmuCmdFsm import mmuPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   cmdValid,
    input  mmuCmdE cmd,
    tlbIf.ctrl     ctrl,
    output logic   regWe,
    output logic   regRe,
    output logic   loadProbe,
    output logic   loadTlbRead,
    output logic   busy,
    output logic   cmdDone
);

    fsmStateE state;
    mmuCmdE   pendingCmd;
    logic     idle;
    logic     commit;
    logic     tlbCmd;

    assign idle   = (state == stateIdle);
    assign commit = (state == stateCommit);
    assign tlbCmd = cmd inside {cmdProbeTlb, cmdReadTlb, cmdWriteTlb, cmdWriteTlbRandom};

    // ####################################################################
    // State register
    // ####################################################################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= stateIdle;
            pendingCmd <= cmdNone;
        end else begin
            case (state)
                stateIdle: begin
                    if (cmdValid && tlbCmd) begin
                        state      <= stateLookup;
                        pendingCmd <= cmd;
                    end
                end
                stateLookup: begin
                    state <= stateCommit;
                end
                default: begin
                    state      <= stateIdle;
                    pendingCmd <= cmdNone;
                end
            endcase
        end
    end

    // Register commands finish in the cycle they arrive
    assign regWe = idle && cmdValid && (cmd == cmdWriteReg);
    assign regRe = idle && cmdValid && (cmd == cmdReadReg);

    // The TLB captures probe and read-back data at the end of lookup
    assign ctrl.readBack = (state == stateLookup) &&
                           (pendingCmd == cmdProbeTlb || pendingCmd == cmdReadTlb);

    assign ctrl.we        = commit &&
                            (pendingCmd == cmdWriteTlb || pendingCmd == cmdWriteTlbRandom);
    assign ctrl.useRandom = commit && (pendingCmd == cmdWriteTlbRandom);
    assign loadProbe      = commit && (pendingCmd == cmdProbeTlb);
    assign loadTlbRead    = commit && (pendingCmd == cmdReadTlb);

    assign busy    = !idle;   // Strobes are dropped while a TLB command runs
    assign cmdDone = commit;

endmodule

// ==== mmu/mmuRegFile.sv ====
`timescale 1ns/1ps

module mmuRegFile import mmuPkg::*; #(
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  regWe,
    input  logic                  regRe,
    input  logic                  loadProbe,
    input  logic                  loadTlbRead,
    input  mmuRegE                regSel,
    input  wordT                  dataIn,
    input  logic [indexWidth-1:0] randomIndex,
    tlbIf.regs                    regs,
    output logic [indexWidth-1:0] wired,
    output logic                  wiredWrite,
    output wordT                  dataOut,
    output logic                  dataValid
);

    localparam wordT probeFailWord = wordT'(1) << indexProbeFailBit;
    localparam wordT indexMask     = probeFailWord | wordT'({indexWidth{1'b1}});

    wordT indexReg;
    wordT entryLo0Reg;
    wordT entryLo1Reg;
    wordT entryHiReg;
    wordT readData;

    // ####################################################################
    // Register writes
    // ####################################################################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            indexReg    <= '0;
            entryLo0Reg <= '0;
            entryLo1Reg <= '0;
            entryHiReg  <= '0;
            wired       <= '0;
        end else if (loadProbe) begin
            indexReg <= regs.probeHit ? wordT'(regs.probeIndex) : probeFailWord;
        end else if (loadTlbRead) begin
            entryHiReg  <= regs.rdEntryHi;
            entryLo0Reg <= regs.rdEntryLo0;
            entryLo1Reg <= regs.rdEntryLo1;
        end else if (regWe) begin
            case (regSel)
                regIndex:    indexReg    <= dataIn & indexMask;
                regEntryLo0: entryLo0Reg <= dataIn;
                regEntryLo1: entryLo1Reg <= dataIn;
                regEntryHi:  entryHiReg  <= dataIn & entryHiMask;
                regWired:    wired       <= dataIn[indexWidth-1:0];
                default:     ;   // Random is read only
            endcase
        end
    end

    assign wiredWrite = regWe && (regSel == regWired);

    assign regs.index    = indexReg;
    assign regs.entryLo0 = entryLo0Reg;
    assign regs.entryLo1 = entryLo1Reg;
    assign regs.entryHi  = entryHiReg;

    // ####################################################################
    // Read port
    // ####################################################################

    always_comb begin
        case (regSel)
            regIndex:    readData = indexReg;
            regRandom:   readData = wordT'(randomIndex);
            regEntryLo0: readData = entryLo0Reg;
            regEntryLo1: readData = entryLo1Reg;
            regEntryHi:  readData = entryHiReg;
            regWired:    readData = wordT'(wired);
            default:     readData = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dataValid <= 1'b0;
        end else begin
            dataValid <= regRe;
        end
    end

    always_ff @(posedge clk) begin
        if (regRe) begin
            dataOut <= readData;
        end
    end

endmodule

// ==== mmu/randomCounter.sv ====
`timescale 1ns/1ps

module randomCounter #(
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [indexWidth-1:0] wired,
    input  logic                  wiredWrite,
    output logic [indexWidth-1:0] randomIndex
);

    localparam logic [indexWidth-1:0] topEntry = '1;

    // Counts down from the top entry to Wired, then wraps
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            randomIndex <= topEntry;
        end else if (wiredWrite) begin
            randomIndex <= topEntry;   // New Wired value takes effect from the top
        end else if (randomIndex <= wired) begin
            randomIndex <= topEntry;
        end else begin
            randomIndex <= randomIndex - 1'b1;
        end
    end

endmodule

// ==== mmu/tlbArray.sv ====
`timescale 1ns/1ps

module tlbArray import mmuPkg::*; #(
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    tlbIf.tlb                     tlb,
    input  wordT                  vAddr,
    output logic                  hit,
    output wordT                  hitLo,
    output logic [indexWidth-1:0] hitIndex
);

    localparam int entryCount = 1 << indexWidth;

    vpn2T                  vpn2Mem [entryCount];
    wordT                  lo0Mem  [entryCount];
    wordT                  lo1Mem  [entryCount];
    logic [entryCount-1:0] entryValid;
    logic [indexWidth-1:0] writeIndex;
    logic [indexWidth-1:0] readIndex;
    logic                  probeMatch;
    logic [indexWidth-1:0] probeMatchIndex;

    // Returns the match flag above the matching entry number
    function automatic logic [indexWidth:0] matchEntry(input vpn2T key);
        logic [indexWidth:0] result;
        result = '0;
        for (int i = 0; i < entryCount; i++) begin
            if (entryValid[i] && vpn2Mem[i] == key) begin
                result = {1'b1, indexWidth'(i)};
            end
        end
        return result;
    endfunction

    assign writeIndex = tlb.useRandom ? tlb.randomIndex : tlb.index[indexWidth-1:0];
    assign readIndex  = tlb.index[indexWidth-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (tlb.we) begin
            entryValid[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb.we) begin
            vpn2Mem[writeIndex] <= tlb.entryHi[31:13];
            lo0Mem[writeIndex]  <= tlb.entryLo0;
            lo1Mem[writeIndex]  <= tlb.entryLo1;
        end
    end

    // Translate and probe ports match independently
    always_comb begin
        {hit, hitIndex}               = matchEntry(vAddr[31:13]);
        {probeMatch, probeMatchIndex} = matchEntry(tlb.entryHi[31:13]);
    end

    assign hitLo = vAddr[12] ? lo1Mem[hitIndex] : lo0Mem[hitIndex];  // Odd page on VA bit 12

    // Held stable through commit for the register load
    always_ff @(posedge clk) begin
        if (tlb.readBack) begin
            tlb.probeHit   <= probeMatch;
            tlb.probeIndex <= probeMatchIndex;
            if (entryValid[readIndex]) begin
                tlb.rdEntryHi  <= {vpn2Mem[readIndex], 13'b0};
                tlb.rdEntryLo0 <= lo0Mem[readIndex];
                tlb.rdEntryLo1 <= lo1Mem[readIndex];
            end else begin
                tlb.rdEntryHi  <= '0;
                tlb.rdEntryLo0 <= '0;
                tlb.rdEntryLo1 <= '0;
            end
        end
    end

endmodule

// ==== project.f ====
common/mmuPkg.sv
common/tlbIf.sv
mmu/mmuCmdFsm.sv
mmu/randomCounter.sv
mmu/mmuRegFile.sv
mmu/tlbArray.sv
mmu/addrTranslator.sv
design/mmuTop.sv
dv/mmuTb_checker.sv
dv/mmuTb.sv
